// ==== common/ising_pkg.sv ====
// sizes, widths and scalar types of the spin problem
`default_nettype none

package ising_pkg;

    // problem size and weight streaming
    localparam int NUM_SPIN     = 16;
    localparam int PARALLELISM  = 4;
    localparam int ROW_BEATS    = NUM_SPIN / PARALLELISM;
    localparam int ROW_ADDR_BIT = $clog2(ROW_BEATS);

    // data widths
    localparam int BITJ          = 4;
    localparam int BITH          = 4;
    localparam int SCALING_BIT   = 4;
    localparam int ENERGY_BIT    = 32;
    localparam int FLIP_ADDR_BIT = 8;

    // bit 1 is spin +1, bit 0 is spin -1
    typedef logic [NUM_SPIN-1:0] spin_t;

    typedef logic signed [ENERGY_BIT-1:0] energy_t;

    // h(i) at bit offset i*BITH
    typedef logic [NUM_SPIN*BITH-1:0] hbias_t;

    typedef logic [FLIP_ADDR_BIT-1:0] flip_addr_t;

    // single coupling and single bias value
    typedef logic signed [BITJ-1:0] coupling_t;
    typedef logic signed [BITH-1:0] bias_t;

endpackage

`default_nettype wire

// ==== common/ising_stream_pkg.sv ====
// payload types of the weight, spin and energy streams
`default_nettype none

package ising_stream_pkg;

    import ising_pkg::*;

    // one matrix row, J(i,j) at j*BITJ
    typedef logic [NUM_SPIN-1:0][BITJ-1:0] j_row_t;

    // row k of a beat is matrix row beat*PARALLELISM+k
    typedef j_row_t [PARALLELISM-1:0] weight_beat_t;

    // candidate sent for evaluation
    typedef struct packed {
        spin_t spin;
        logic  last;
    } spin_req_t;

    // evaluated candidate
    typedef struct packed {
        energy_t energy;
        spin_t   spin;
        logic    last;
    } energy_rsp_t;

endpackage

`default_nettype wire

// ==== energy_monitor/energy_monitor.sv ====
// streaming Ising energy calculator
// consumes one spin and ROW_BEATS weight beats per result
`default_nettype none

module energy_monitor #(
    parameter bit H_IS_NEGATIVE = 1'b0
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               spin_valid_i,
    input  ising_stream_pkg::spin_req_t        spin_i,
    output logic                               spin_ready_o,
    input  logic                               beat_valid_i,
    input  ising_stream_pkg::weight_beat_t     beat_i,
    output logic                               beat_ready_o,
    input  ising_pkg::hbias_t                  hbias_i,
    input  logic [ising_pkg::SCALING_BIT-1:0]  hscaling_i,
    output logic                               energy_valid_o,
    output ising_stream_pkg::energy_rsp_t      energy_o,
    input  logic                               energy_ready_i
);

    import ising_pkg::*;
    import ising_stream_pkg::*;

    logic                        busy_q;
    logic                        done_q;
    logic                        res_valid_q;
    logic [ROW_ADDR_BIT-1:0]     beat_cnt_q;
    spin_t                       spin_q;
    logic                        last_q;
    energy_t                     acc_q;
    energy_rsp_t                 res_q;
    logic [PARALLELISM*BITH-1:0] hsel;
    energy_t                     beat_sum;
    logic                        spin_acc;
    logic                        beat_acc;
    logic                        res_load;
    logic                        res_pop;

    // next spin may enter while a result still waits
    assign spin_ready_o = !busy_q && !done_q;
    assign beat_ready_o = busy_q;

    assign spin_acc = spin_valid_i && spin_ready_o;
    assign beat_acc = beat_valid_i && beat_ready_o;
    assign res_pop  = res_valid_q && energy_ready_i;
    assign res_load = done_q && (!res_valid_q || energy_ready_i);

    // bias values of the rows in the current beat
    assign hsel = hbias_i[beat_cnt_q * PARALLELISM * BITH +: PARALLELISM * BITH];

    always_comb begin : row_sum
        coupling_t                   j_val;
        bias_t                       h_val;
        logic signed [SCALING_BIT:0] scale;
        energy_t                     field;
        int                          row;

        beat_sum = '0;
        scale    = {1'b0, hscaling_i};
        for (int k = 0; k < PARALLELISM; k++) begin
            row   = int'(beat_cnt_q) * PARALLELISM + k;
            h_val = hsel[k*BITH +: BITH];
            field = h_val * scale;
            for (int j = 0; j < NUM_SPIN; j++) begin
                j_val = beat_i[k][j];
                if (spin_q[j]) begin
                    field = field + j_val;
                end else begin
                    field = field - j_val;
                end
            end
            // weight the field by the row's own spin
            if (spin_q[row]) begin
                beat_sum = beat_sum + field;
            end else begin
                beat_sum = beat_sum - field;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            res_valid_q <= 1'b0;
            beat_cnt_q  <= '0;
        end else begin
            if (spin_acc) begin
                busy_q     <= 1'b1;
                beat_cnt_q <= '0;
            end
            if (beat_acc) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                if (beat_cnt_q == ROW_ADDR_BIT'(ROW_BEATS - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
            // done waits here until the result register is free
            if (res_load) begin
                done_q      <= 1'b0;
                res_valid_q <= 1'b1;
            end else if (res_pop) begin
                res_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (spin_acc) begin
            spin_q <= spin_i.spin;
            last_q <= spin_i.last;
            acc_q  <= '0;
        end
        if (beat_acc) begin
            acc_q <= acc_q + beat_sum;
        end
        if (res_load) begin
            res_q.energy <= H_IS_NEGATIVE ? -acc_q : acc_q;
            res_q.spin   <= spin_q;
            res_q.last   <= last_q;
        end
    end

    assign energy_valid_o = res_valid_q;
    assign energy_o       = res_q;

endmodule

`default_nettype wire

// ==== flip_manager/flip_manager.sv ====
// search controller holding the best spin and energy
// builds candidates from flip patterns in the flip memory
`default_nettype none

module flip_manager #(
    parameter int FLIP_DEPTH = 256
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           config_valid_i,
    input  ising_pkg::spin_t               config_spin_i,
    input  logic                           cmpt_start_i,
    input  logic                           en_comparison_i,
    input  ising_pkg::flip_addr_t          flip_count_i,
    output logic                           cmpt_idle_o,
    output logic                           flip_ren_o,
    output ising_pkg::flip_addr_t          flip_raddr_o,
    input  ising_pkg::spin_t               flip_rdata_i,
    output logic                           spin_valid_o,
    output ising_stream_pkg::spin_req_t    spin_o,
    input  logic                           spin_ready_i,
    input  logic                           energy_valid_i,
    input  ising_stream_pkg::energy_rsp_t  energy_i,
    output logic                           energy_ready_o,
    output ising_pkg::spin_t               best_spin_o,
    output ising_pkg::energy_t             best_energy_o
);

    import ising_pkg::*;
    import ising_stream_pkg::*;

    // flip patterns available per search
    localparam int MAX_FLIPS = (FLIP_DEPTH > 255) ? 255 : FLIP_DEPTH;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT,
        ST_COMPARE,
        ST_FLIP_RD,
        ST_FLIP_DATA
    } state_e;

    state_e      state_q;
    logic        start_q;
    logic        start_edge;
    logic        first_q;
    flip_addr_t  idx_q;
    flip_addr_t  count_q;
    flip_addr_t  count_lim;
    spin_t       cfg_spin_q;
    spin_t       best_spin_q;
    energy_t     best_energy_q;
    spin_req_t   cand_q;
    energy_rsp_t rsp_q;
    logic        better;

    assign start_edge = cmpt_start_i && !start_q;
    assign count_lim  = (flip_count_i > MAX_FLIPS) ? flip_addr_t'(MAX_FLIPS) : flip_count_i;

    // first response always wins, no comparison gives a random walk
    assign better = first_q || !en_comparison_i || (rsp_q.energy < best_energy_q);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q       <= ST_IDLE;
            start_q       <= 1'b0;
            first_q       <= 1'b0;
            idx_q         <= '0;
            count_q       <= '0;
            best_spin_q   <= '0;
            best_energy_q <= '0;
        end else begin
            start_q <= cmpt_start_i;
            case (state_q)
                ST_IDLE: begin
                    if (start_edge) begin
                        count_q <= count_lim;
                        idx_q   <= '0;
                        first_q <= 1'b1;
                        state_q <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (spin_ready_i) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (energy_valid_i) begin
                        state_q <= ST_COMPARE;
                    end
                end
                ST_COMPARE: begin
                    if (better) begin
                        best_spin_q   <= rsp_q.spin;
                        best_energy_q <= rsp_q.energy;
                    end
                    first_q <= 1'b0;
                    state_q <= rsp_q.last ? ST_IDLE : ST_FLIP_RD;
                end
                ST_FLIP_RD: begin
                    state_q <= ST_FLIP_DATA;
                end
                ST_FLIP_DATA: begin
                    idx_q   <= idx_q + 1'b1;
                    state_q <= ST_ISSUE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (config_valid_i) begin
            cfg_spin_q <= config_spin_i;
        end
        // candidate 0 is the loaded spin
        if (state_q == ST_IDLE && start_edge) begin
            cand_q.spin <= cfg_spin_q;
            cand_q.last <= count_lim == '0;
        end
        // flip pattern arrives one cycle after the read
        if (state_q == ST_FLIP_DATA) begin
            cand_q.spin <= best_spin_q ^ flip_rdata_i;
            cand_q.last <= flip_addr_t'(idx_q + 1'b1) == count_q;
        end
        if (state_q == ST_WAIT && energy_valid_i) begin
            rsp_q <= energy_i;
        end
    end

    assign cmpt_idle_o    = state_q == ST_IDLE;
    assign flip_ren_o     = state_q == ST_FLIP_RD;
    assign flip_raddr_o   = idx_q;
    assign spin_valid_o   = state_q == ST_ISSUE;
    assign spin_o         = cand_q;
    assign energy_ready_o = state_q == ST_WAIT;
    assign best_spin_o    = best_spin_q;
    assign best_energy_o  = best_energy_q;

endmodule

`default_nettype wire

// ==== logic/digital_macro.sv ====
// solver top level
// weight fetcher, energy monitor and flip manager
`default_nettype none

module digital_macro #(
    parameter int FIFO_DEPTH    = 2,
    parameter bit H_IS_NEGATIVE = 1'b0,
    parameter int FLIP_DEPTH    = 256
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               flush_i,
    input  logic                               config_valid_i,
    input  ising_pkg::spin_t                   config_spin_i,
    input  logic                               cmpt_start_i,
    input  logic                               en_comparison_i,
    input  ising_pkg::flip_addr_t              flip_count_i,
    input  ising_pkg::hbias_t                  hbias_i,
    input  logic [ising_pkg::SCALING_BIT-1:0]  hscaling_i,
    output logic                               weight_ren_o,
    output logic [ising_pkg::ROW_ADDR_BIT-1:0] weight_raddr_o,
    input  ising_stream_pkg::weight_beat_t     weight_rdata_i,
    output logic                               flip_ren_o,
    output ising_pkg::flip_addr_t              flip_raddr_o,
    input  ising_pkg::spin_t                   flip_rdata_i,
    output logic                               cmpt_idle_o,
    output ising_pkg::spin_t                   best_spin_o,
    output ising_pkg::energy_t                 best_energy_o
);

    import ising_stream_pkg::*;

    logic         beat_valid;
    logic         beat_ready;
    weight_beat_t beat;
    logic         spin_valid;
    logic         spin_ready;
    spin_req_t    spin_req;
    logic         energy_valid;
    logic         energy_ready;
    energy_rsp_t  energy_rsp;

    weight_fetch #(
        .FIFO_DEPTH     (FIFO_DEPTH     )
    ) u_weight_fetch (
        .clk_i          (clk_i          ),
        .rst_i          (rst_i          ),
        .flush_i        (flush_i        ),
        .mem_ren_o      (weight_ren_o   ),
        .mem_raddr_o    (weight_raddr_o ),
        .mem_rdata_i    (weight_rdata_i ),
        .beat_valid_o   (beat_valid     ),
        .beat_o         (beat           ),
        .beat_ready_i   (beat_ready     )
    );

    energy_monitor #(
        .H_IS_NEGATIVE  (H_IS_NEGATIVE  )
    ) u_energy_monitor (
        .clk_i          (clk_i          ),
        .rst_i          (rst_i          ),
        .spin_valid_i   (spin_valid     ),
        .spin_i         (spin_req       ),
        .spin_ready_o   (spin_ready     ),
        .beat_valid_i   (beat_valid     ),
        .beat_i         (beat           ),
        .beat_ready_o   (beat_ready     ),
        .hbias_i        (hbias_i        ),
        .hscaling_i     (hscaling_i     ),
        .energy_valid_o (energy_valid   ),
        .energy_o       (energy_rsp     ),
        .energy_ready_i (energy_ready   )
    );

    flip_manager #(
        .FLIP_DEPTH     (FLIP_DEPTH     )
    ) u_flip_manager (
        .clk_i          (clk_i          ),
        .rst_i          (rst_i          ),
        .config_valid_i (config_valid_i ),
        .config_spin_i  (config_spin_i  ),
        .cmpt_start_i   (cmpt_start_i   ),
        .en_comparison_i(en_comparison_i),
        .flip_count_i   (flip_count_i   ),
        .cmpt_idle_o    (cmpt_idle_o    ),
        .flip_ren_o     (flip_ren_o     ),
        .flip_raddr_o   (flip_raddr_o   ),
        .flip_rdata_i   (flip_rdata_i   ),
        .spin_valid_o   (spin_valid     ),
        .spin_o         (spin_req       ),
        .spin_ready_i   (spin_ready     ),
        .energy_valid_i (energy_valid   ),
        .energy_i       (energy_rsp     ),
        .energy_ready_o (energy_ready   ),
        .best_spin_o    (best_spin_o    ),
        .best_energy_o  (best_energy_o  )
    );

endmodule

`default_nettype wire

// ==== sim/digital_macro_asserts.sv ====
// handshake checks on the spin, weight and energy streams of the energy monitor
`default_nettype none

module digital_macro_asserts (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            spin_valid_i,
    input  ising_stream_pkg::spin_req_t     spin_i,
    input  logic                            spin_ready_o,
    input  logic                            beat_valid_i,
    input  ising_stream_pkg::weight_beat_t  beat_i,
    input  logic                            beat_ready_o,
    input  logic                            energy_valid_o,
    input  ising_stream_pkg::energy_rsp_t   energy_o,
    input  logic                            energy_ready_i
);

    int unsigned fail_cnt = 0;

    // a stalled transfer keeps valid high and the payload steady
    spin_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        spin_valid_i && !spin_ready_o |=> spin_valid_i && $stable(spin_i))
        else begin
            fail_cnt++;
            $error("spin stream dropped valid or changed payload while stalled");
        end

    beat_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        beat_valid_i && !beat_ready_o |=> beat_valid_i && $stable(beat_i))
        else begin
            fail_cnt++;
            $error("weight stream dropped valid or changed payload while stalled");
        end

    energy_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        energy_valid_o && !energy_ready_i |=> energy_valid_o && $stable(energy_o))
        else begin
            fail_cnt++;
            $error("energy stream dropped valid or changed payload while stalled");
        end

endmodule

bind energy_monitor digital_macro_asserts u_handshake_asserts (
    .clk_i          (clk_i          ),
    .rst_i          (rst_i          ),
    .spin_valid_i   (spin_valid_i   ),
    .spin_i         (spin_i         ),
    .spin_ready_o   (spin_ready_o   ),
    .beat_valid_i   (beat_valid_i   ),
    .beat_i         (beat_i         ),
    .beat_ready_o   (beat_ready_o   ),
    .energy_valid_o (energy_valid_o ),
    .energy_o       (energy_o       ),
    .energy_ready_i (energy_ready_i )
);

`default_nettype wire

// ==== sim/tb_digital_macro.sv ====
// testbench for the solver top level
// memory models, reference energy and search, checks and watchdog
`default_nettype none

module tb_digital_macro;

    import ising_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int FIFO_DEPTH    = 2;
    localparam bit H_IS_NEGATIVE = 1'b0;
    localparam int FLIP_DEPTH    = 256;
    localparam int NUM_TESTS     = 5;
    localparam int FLIP_COUNT    = 20;
    localparam int FLUSH_AT      = 5;
    localparam int BEAT_BIT      = PARALLELISM * NUM_SPIN * BITJ;

    logic                      clk;
    logic                      rst;
    logic                      flush;
    logic                      config_valid;
    spin_t                     config_spin;
    logic                      cmpt_start;
    logic                      en_comparison;
    flip_addr_t                flip_count;
    hbias_t                    hbias;
    logic [SCALING_BIT-1:0]    hscaling;
    logic                      weight_ren;
    logic [ROW_ADDR_BIT-1:0]   weight_raddr;
    logic [BEAT_BIT-1:0]       weight_rdata;
    logic                      flip_ren;
    flip_addr_t                flip_raddr;
    spin_t                     flip_rdata;
    logic                      cmpt_idle;
    spin_t                     best_spin;
    energy_t                   best_energy;

    logic [BEAT_BIT-1:0] wmem [ROW_BEATS];
    spin_t               fmem [FLIP_DEPTH];
    integer              seed;
    event                check_ev;
    int                  cur_test;
    string               cur_name;
    spin_t               exp_spin;
    int                  exp_energy;
    int                  test_errs;
    int                  mismatches;
    int                  tests_run;
    int                  tests_failed;

    digital_macro #(
        .FIFO_DEPTH     (FIFO_DEPTH     ),
        .H_IS_NEGATIVE  (H_IS_NEGATIVE  ),
        .FLIP_DEPTH     (FLIP_DEPTH     )
    ) UUT (
        .clk_i          (clk            ),
        .rst_i          (rst            ),
        .flush_i        (flush          ),
        .config_valid_i (config_valid   ),
        .config_spin_i  (config_spin    ),
        .cmpt_start_i   (cmpt_start     ),
        .en_comparison_i(en_comparison  ),
        .flip_count_i   (flip_count     ),
        .hbias_i        (hbias          ),
        .hscaling_i     (hscaling       ),
        .weight_ren_o   (weight_ren     ),
        .weight_raddr_o (weight_raddr   ),
        .weight_rdata_i (weight_rdata   ),
        .flip_ren_o     (flip_ren       ),
        .flip_raddr_o   (flip_raddr     ),
        .flip_rdata_i   (flip_rdata     ),
        .cmpt_idle_o    (cmpt_idle      ),
        .best_spin_o    (best_spin      ),
        .best_energy_o  (best_energy    )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // one cycle read latency on both memories
    always @(posedge clk) begin
        if (weight_ren) begin
            weight_rdata <= wmem[weight_raddr];
        end
        if (flip_ren) begin
            flip_rdata <= fmem[flip_raddr];
        end
    end

    // energy by the spin rule, J(i,j) from row i of beat i/PARALLELISM
    function automatic int ref_energy(input spin_t s);
        int e;
        int field;
        int jv;
        int hv;
        e = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            hv    = $signed(hbias[i*BITH +: BITH]);
            field = hv * int'(hscaling);
            for (int j = 0; j < NUM_SPIN; j++) begin
                jv = $signed(wmem[i / PARALLELISM][(i % PARALLELISM) * NUM_SPIN * BITJ
                                                   + j * BITJ +: BITJ]);
                field = field + (s[j] ? jv : -jv);
            end
            e = e + (s[i] ? field : -field);
        end
        return H_IS_NEGATIVE ? -e : e;
    endfunction

    function automatic void ref_search(input spin_t start, input bit cmp, input int count,
                                       output spin_t best, output int best_e);
        spin_t cand;
        int    e;
        best   = start;
        best_e = ref_energy(start);
        for (int k = 1; k <= count; k++) begin
            cand = best ^ fmem[k-1];
            e    = ref_energy(cand);
            if (!cmp || e < best_e) begin
                best   = cand;
                best_e = e;
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            mismatches++;
            test_errs++;
        end
    endtask

    task automatic request_check(input int num, input string name, input spin_t spin,
                                 input int energy);
        cur_test   = num;
        cur_name   = name;
        exp_spin   = spin;
        exp_energy = energy;
        -> check_ev;
        @(posedge clk);
        #1;
    endtask

    task automatic load_config(input spin_t s);
        @(posedge clk);
        #1;
        config_valid = 1'b1;
        config_spin  = s;
        @(posedge clk);
        #1;
        config_valid = 1'b0;
    endtask

    task automatic run_search(input bit with_flush);
        @(posedge clk);
        #1;
        cmpt_start = 1'b1;
        @(posedge clk);
        #1;
        cmpt_start = 1'b0;
        if (with_flush) begin
            // fetcher refilling from beat 0 means the FIFO is empty
            while (!(weight_ren && weight_raddr == '0 && flip_raddr >= FLUSH_AT)) begin
                @(posedge clk);
                #1;
            end
            flush = 1'b1;
            @(posedge clk);
            #1;
            flush = 1'b0;
        end
        while (!cmpt_idle) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin : compare
        forever begin
            @(check_ev);
            test_errs = 0;
            if (cur_test == 1) begin
                check_value("cmpt_idle_o", cmpt_idle, 1'b1);
                check_value("weight_ren_o", weight_ren, 1'b0);
                check_value("flip_ren_o", flip_ren, 1'b0);
            end
            check_value("best_spin_o", best_spin, exp_spin);
            check_value("best_energy_o", best_energy, exp_energy);
            tests_run++;
            if (test_errs != 0) begin
                tests_failed++;
            end
            $display("test %0d (%s): %s", cur_test, cur_name, (test_errs == 0) ? "ok" : "bad");
        end
    end

    initial begin : watchdog
        #(NUM_TESTS * (FLIP_COUNT + 1) * 40 * CLK_PERIOD);
        $display("timeout: the searches did not finish within the cycle budget");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : stimulus
        spin_t cfg_a;
        spin_t cfg_b;
        spin_t walk;
        spin_t t3_spin;
        int    t3_energy;
        int    asrt_fails;
        rst           = 1'b1;
        flush         = 1'b0;
        config_valid  = 1'b0;
        config_spin   = '0;
        cmpt_start    = 1'b0;
        en_comparison = 1'b1;
        flip_count    = '0;
        hbias         = '0;
        hscaling      = '0;
        weight_rdata  = '0;
        flip_rdata    = '0;
        mismatches    = 0;
        tests_run     = 0;
        tests_failed  = 0;
        seed          = 32'he1bc_b51c;
        for (int b = 0; b < ROW_BEATS; b++) begin
            for (int w = 0; w < BEAT_BIT / 32; w++) begin
                wmem[b][w*32 +: 32] = $random(seed);
            end
        end
        for (int a = 0; a < FLIP_DEPTH; a++) begin
            fmem[a] = spin_t'($random(seed));
        end
        hbias    = {$random(seed), $random(seed)};
        hscaling = SCALING_BIT'($random(seed));
        cfg_a    = spin_t'($random(seed));
        cfg_b    = spin_t'($random(seed));

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        request_check(1, "reset state", '0, 0);

        load_config(cfg_a);
        run_search(1'b0);
        request_check(2, "loaded spin only", cfg_a, ref_energy(cfg_a));

        flip_count = FLIP_COUNT;
        run_search(1'b0);
        ref_search(cfg_a, 1'b1, FLIP_COUNT, t3_spin, t3_energy);
        request_check(3, "search with comparison", t3_spin, t3_energy);

        // random walk takes every candidate
        load_config(cfg_b);
        en_comparison = 1'b0;
        run_search(1'b0);
        walk = cfg_b;
        for (int k = 0; k < FLIP_COUNT; k++) begin
            walk = walk ^ fmem[k];
        end
        request_check(4, "random walk", walk, ref_energy(walk));

        en_comparison = 1'b1;
        run_search(1'b1);
        load_config(cfg_a);
        run_search(1'b0);
        request_check(5, "flush then restart", t3_spin, t3_energy);

        asrt_fails = UUT.u_energy_monitor.u_handshake_asserts.fail_cnt;
        $display("%0d tests run, %0d failed, %0d mismatches, %0d assertion failures",
                 tests_run, tests_failed, mismatches, asrt_fails);
        if (tests_failed == 0 && asrt_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/ising_pkg.sv
common/ising_stream_pkg.sv
weight_fetch/weight_fetch.sv
energy_monitor/energy_monitor.sv
flip_manager/flip_manager.sv
logic/digital_macro.sv
sim/digital_macro_asserts.sv
sim/tb_digital_macro.sv

// ==== weight_fetch/weight_fetch.sv ====
// weight memory reader feeding a small FIFO
// valid/ready output towards the energy monitor
`default_nettype none

module weight_fetch #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                flush_i,
    output logic                                mem_ren_o,
    output logic [ising_pkg::ROW_ADDR_BIT-1:0]  mem_raddr_o,
    input  ising_stream_pkg::weight_beat_t      mem_rdata_i,
    output logic                                beat_valid_o,
    output ising_stream_pkg::weight_beat_t      beat_o,
    input  logic                                beat_ready_i
);

    import ising_pkg::*;
    import ising_stream_pkg::*;

    localparam int PTR_BIT = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_BIT = $clog2(FIFO_DEPTH + 1);

    logic [ROW_ADDR_BIT-1:0] addr_q;
    logic                    ren_q;
    logic                    inflight_q;
    logic [CNT_BIT-1:0]      count_q;
    logic [PTR_BIT-1:0]      wptr_q;
    logic [PTR_BIT-1:0]      rptr_q;
    weight_beat_t            fifo_q [FIFO_DEPTH];
    logic [CNT_BIT+1:0]      pending;
    logic                    issue;
    logic                    push;
    logic                    pop;

    function automatic logic [PTR_BIT-1:0] next_ptr(input logic [PTR_BIT-1:0] ptr);
        if (ptr == PTR_BIT'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // memory data lands one cycle after the read
    assign push = inflight_q;
    assign pop  = beat_valid_o && beat_ready_i;

    // stored entries plus reads not yet landed, acts as a credit count
    assign pending = count_q + ren_q + inflight_q;
    assign issue   = pending < FIFO_DEPTH;

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            ren_q      <= 1'b0;
            inflight_q <= 1'b0;
            addr_q     <= '0;
            count_q    <= '0;
            wptr_q     <= '0;
            rptr_q     <= '0;
        end else begin
            ren_q      <= issue;
            inflight_q <= ren_q;
            if (ren_q) begin
                if (addr_q == ROW_ADDR_BIT'(ROW_BEATS - 1)) begin
                    addr_q <= '0;
                end else begin
                    addr_q <= addr_q + 1'b1;
                end
            end
            if (push) begin
                wptr_q <= next_ptr(wptr_q);
            end
            if (pop) begin
                rptr_q <= next_ptr(rptr_q);
            end
            count_q <= count_q + push - pop;
        end
    end

    // fifo storage
    always_ff @(posedge clk_i) begin
        if (push && !flush_i) begin
            fifo_q[wptr_q] <= mem_rdata_i;
        end
    end

    assign mem_ren_o    = ren_q;
    assign mem_raddr_o  = addr_q;
    assign beat_valid_o = count_q != '0;
    assign beat_o       = fifo_q[rptr_q];

endmodule

`default_nettype wire
